// File: ma_unit.f
+incdir+test
source/ma_pkg.sv
source/ma_mult_pipe.sv
source/ma_add_pipe.sv
source/ma_issue_ctrl.sv
source/ma_unit.sv
source/ma_csr.sv
source/ma_top.sv
test/ma_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module ma_tb -f ma_unit.f \
	--Mdir obj_dir -o ma_sim

./obj_dir/ma_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
fi
exit 1

// File: source/ma_add_pipe.sv
// One-stage integer add/subtract pipeline with its result token.
`timescale 1ns/1ps

module ma_add_pipe (
	input	logic					clock,
	input	logic					rst_n,
	input	logic					stall,
	input	logic					in_valid,
	input	logic					sub,
	input	ma_pkg::data_t			a,
	input	ma_pkg::data_t			b,
	input	ma_pkg::ma_add_tok_t	in_tok,
	output	logic					out_valid,
	output	ma_pkg::data_t			sum,
	output	ma_pkg::ma_add_tok_t	out_tok
);

	logic					valid_q;
	ma_pkg::data_t			sum_q;
	ma_pkg::ma_add_tok_t	tok_q;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (!stall) begin
			valid_q <= in_valid;
		end
	end

	// Wraps modulo 2^32.
	always_ff @(posedge clock) begin
		if (!stall && in_valid) begin
			sum_q <= sub ? (a - b) : (a + b);
			tok_q <= in_tok;
		end
	end

	assign out_valid	= valid_q;
	assign sum			= sum_q;
	assign out_tok		= tok_q;

endmodule

// File: source/ma_csr.sv
// Wishbone classic register block holding the enable, the MAC bias and the retired-result count.
`timescale 1ns/1ps

module ma_csr (
	input	logic				clock,
	input	logic				rst_n,
	input	ma_pkg::wb_req_t	wb_i,
	output	ma_pkg::wb_rsp_t	wb_o,
	input	logic				res_valid,
	output	logic				enable,
	output	ma_pkg::data_t		mac_bias
);

	logic			ack_q;
	logic			hit;
	ma_pkg::data_t	rdata_q;
	ma_pkg::data_t	rdata;
	logic			enable_q;
	ma_pkg::data_t	bias_q;
	ma_pkg::data_t	count_q;

	// New cycle seen; no second ack while the master still holds stb.
	assign hit = wb_i.cyc & wb_i.stb & ~ack_q;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			enable_q	<= 1'b0;
			bias_q		<= '0;
		end else if (hit && wb_i.we) begin
			case (wb_i.adr)
				ma_pkg::REG_CTRL:	enable_q <= wb_i.dat_w[0];
				ma_pkg::REG_BIAS:	bias_q <= wb_i.dat_w;
				default:			;	// Count is read-only.
			endcase
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			count_q <= '0;
		end else if (res_valid) begin
			count_q <= count_q + 1'b1;	// Wraps.
		end
	end

	always_comb begin
		case (wb_i.adr)
			ma_pkg::REG_CTRL:	rdata = {31'd0, enable_q};
			ma_pkg::REG_BIAS:	rdata = bias_q;
			ma_pkg::REG_COUNT:	rdata = count_q;
			default:			rdata = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (hit) begin
			rdata_q <= rdata;
		end
	end

	assign wb_o.ack		= ack_q;
	assign wb_o.dat_r	= rdata_q;
	assign enable		= enable_q;
	assign mac_bias		= bias_q;

endmodule

// File: source/ma_issue_ctrl.sv
// Completion-slot reservation pipeline that admits a request only if its result slot is free.
`timescale 1ns/1ps

module ma_issue_ctrl (
	input	logic			clock,
	input	logic			rst_n,
	input	logic			stall,
	input	logic			enable,
	input	logic			req_valid,
	input	ma_pkg::op_t	op,
	output	logic			ready
);

	// Bit k set means a result already leaves k+1 cycles from now.
	logic [ma_pkg::LAT_CHAIN-1:0]	slots_q;
	logic [ma_pkg::LAT_CHAIN-1:0]	want;
	logic							accept;

	function automatic int unsigned op_latency(ma_pkg::op_t o);
		int unsigned lat;
		lat = ma_pkg::LAT_MLT;
		if (o.op_class == ma_pkg::OP_CLASS_ADD) begin
			lat = ma_pkg::LAT_ADD;
		end else begin
			case (o.op_code)
				ma_pkg::OP_MUL:					lat = ma_pkg::LAT_MLT;
				ma_pkg::OP_MAC, ma_pkg::OP_MAD:	lat = ma_pkg::LAT_CHAIN;
				default:						lat = ma_pkg::LAT_MLT;
			endcase
		end
		return lat;
	endfunction

	// One-hot slot that this op would complete in.
	assign want		= (ma_pkg::LAT_CHAIN)'(1) << (op_latency(op) - 1);

	assign ready	= enable & ~stall & ~|(slots_q & want);
	assign accept	= req_valid & ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			slots_q <= '0;
		end else if (!stall) begin
			slots_q <= (slots_q | (accept ? want : '0)) >> 1;	// Advance one cycle.
		end
	end

endmodule

// File: source/ma_mult_pipe.sv
// Integer multiplier pipeline that carries a token alongside each product.
`timescale 1ns/1ps

module ma_mult_pipe (
	input	logic					clock,
	input	logic					rst_n,
	input	logic					stall,
	input	logic					in_valid,
	input	ma_pkg::data_t			a,
	input	ma_pkg::data_t			b,
	input	ma_pkg::ma_mlt_tok_t	in_tok,
	output	logic					out_valid,
	output	ma_pkg::data_t			product,
	output	ma_pkg::ma_mlt_tok_t	out_tok
);

	logic [ma_pkg::DEPTH_MLT-1:0]	valid_q;
	ma_pkg::data_t					a_q;
	ma_pkg::data_t					b_q;
	ma_pkg::data_t					prod_q [ma_pkg::DEPTH_MLT-1];
	ma_pkg::ma_mlt_tok_t			tok_q [ma_pkg::DEPTH_MLT];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (!stall) begin
			valid_q <= {valid_q[ma_pkg::DEPTH_MLT-2:0], in_valid};
		end
	end

	// Stage one takes the operands, stage two multiplies, the rest delay.
	always_ff @(posedge clock) begin
		if (!stall) begin
			a_q <= a;
			b_q <= b;
			prod_q[0] <= a_q * b_q;	// Low word only.
			for (int i = 1; i < ma_pkg::DEPTH_MLT - 1; i++) begin
				prod_q[i] <= prod_q[i-1];
			end
			tok_q[0] <= in_tok;
			for (int i = 1; i < ma_pkg::DEPTH_MLT; i++) begin
				tok_q[i] <= tok_q[i-1];
			end
		end
	end

	assign out_valid	= valid_q[ma_pkg::DEPTH_MLT-1];
	assign product		= prod_q[ma_pkg::DEPTH_MLT-2];
	assign out_tok		= tok_q[ma_pkg::DEPTH_MLT-1];

endmodule

// File: source/ma_pkg.sv
// Shared types, operation encodings, latencies and register map of the multiply-add unit.
package ma_pkg;

	typedef logic [31:0]	data_t;
	typedef logic [7:0]		issue_no_t;
	typedef logic [1:0]		op_class_t;
	typedef logic [1:0]		op_code_t;
	typedef logic [3:0]		wb_adr_t;	// Byte address.

	localparam int DEPTH_MLT	= 3;
	localparam int DEPTH_ADD	= 1;

	// Acceptance to result, in unstalled cycles.
	localparam int LAT_ADD		= DEPTH_ADD;
	localparam int LAT_MLT		= DEPTH_MLT;
	localparam int LAT_CHAIN	= DEPTH_MLT + DEPTH_ADD;

	localparam op_class_t OP_CLASS_ADD	= 2'd0;
	localparam op_class_t OP_CLASS_MLT	= 2'd1;

	localparam op_code_t OP_ADD	= 2'd0;
	localparam op_code_t OP_SUB	= 2'd1;
	localparam op_code_t OP_MUL	= 2'd0;
	localparam op_code_t OP_MAC	= 2'd2;	// Product plus bias register.
	localparam op_code_t OP_MAD	= 2'd3;	// Product plus data3.

	localparam wb_adr_t REG_CTRL	= 4'h0;
	localparam wb_adr_t REG_BIAS	= 4'h4;
	localparam wb_adr_t REG_COUNT	= 4'h8;

	typedef struct packed {
		op_class_t	op_class;
		op_code_t	op_code;
	} op_t;

	typedef struct packed {
		op_t		op;
		issue_no_t	issue_no;
		data_t		data1;
		data_t		data2;
		data_t		data3;
	} ma_req_t;

	typedef struct packed {
		issue_no_t	issue_no;
		data_t		data;
	} ma_res_t;

	typedef struct packed {
		logic		chain;		// Send the product on to the adder.
		issue_no_t	issue_no;
		data_t		addend;
	} ma_mlt_tok_t;

	typedef struct packed {
		issue_no_t	issue_no;
	} ma_add_tok_t;

	typedef struct packed {
		logic		cyc;
		logic		stb;
		logic		we;
		wb_adr_t	adr;
		data_t		dat_w;
	} wb_req_t;

	typedef struct packed {
		logic		ack;
		data_t		dat_r;
	} wb_rsp_t;

endpackage

// File: source/ma_top.sv
// Top level joining the multiply-add unit with its Wishbone register block.
`timescale 1ns/1ps

module ma_top (
	input	logic				clock,
	input	logic				rst_n,
	input	logic				stall,
	input	logic				req_valid,
	input	ma_pkg::ma_req_t	req,
	output	logic				req_ready,
	output	logic				res_valid,
	output	ma_pkg::ma_res_t	res,
	input	ma_pkg::wb_req_t	wb_i,
	output	ma_pkg::wb_rsp_t	wb_o
);

	logic			enable;
	ma_pkg::data_t	mac_bias;

	// Retired results also feed the counter.
	ma_unit unit (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.stall(		stall		),
		.enable(	enable		),
		.mac_bias(	mac_bias	),
		.req_valid(	req_valid	),
		.req(		req			),
		.req_ready(	req_ready	),
		.res_valid(	res_valid	),
		.res(		res			)
	);

	ma_csr csr (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.wb_i(		wb_i		),
		.wb_o(		wb_o		),
		.res_valid(	res_valid	),
		.enable(	enable		),
		.mac_bias(	mac_bias	)
	);

endmodule

// File: source/ma_unit.sv
// Multiply-add execution unit: routes requests to the pipelines, chains MAD/MAC, merges results.
`timescale 1ns/1ps

module ma_unit (
	input	logic				clock,
	input	logic				rst_n,
	input	logic				stall,
	input	logic				enable,
	input	ma_pkg::data_t		mac_bias,
	input	logic				req_valid,
	input	ma_pkg::ma_req_t	req,
	output	logic				req_ready,
	output	logic				res_valid,
	output	ma_pkg::ma_res_t	res
);

	logic					accept;
	logic					is_add;
	logic					is_mlt;

	logic					mlt_in_valid;
	ma_pkg::ma_mlt_tok_t	mlt_in_tok;
	logic					mlt_out_valid;
	ma_pkg::data_t			product;
	ma_pkg::ma_mlt_tok_t	mlt_out_tok;
	logic					chain_go;
	logic					mlt_done;

	logic					add_in_valid;
	logic					add_sub;
	ma_pkg::data_t			add_a;
	ma_pkg::data_t			add_b;
	ma_pkg::ma_add_tok_t	add_in_tok;
	logic					add_out_valid;
	ma_pkg::data_t			sum;
	ma_pkg::ma_add_tok_t	add_out_tok;

	assign accept	= req_valid & req_ready;
	assign is_add	= (req.op.op_class == ma_pkg::OP_CLASS_ADD);
	assign is_mlt	= (req.op.op_class == ma_pkg::OP_CLASS_MLT);

	ma_issue_ctrl issue_ctrl (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.stall(		stall		),
		.enable(	enable		),
		.req_valid(	req_valid	),
		.op(		req.op		),
		.ready(		req_ready	)
	);

	// Bias is sampled here, at acceptance.
	assign mlt_in_valid			= accept & is_mlt;
	assign mlt_in_tok.chain		= (req.op.op_code == ma_pkg::OP_MAC) |
								  (req.op.op_code == ma_pkg::OP_MAD);
	assign mlt_in_tok.issue_no	= req.issue_no;
	assign mlt_in_tok.addend	= (req.op.op_code == ma_pkg::OP_MAD) ? req.data3 : mac_bias;

	ma_mult_pipe mult_pipe (
		.clock(		clock			),
		.rst_n(		rst_n			),
		.stall(		stall			),
		.in_valid(	mlt_in_valid	),
		.a(			req.data1		),
		.b(			req.data2		),
		.in_tok(	mlt_in_tok		),
		.out_valid(	mlt_out_valid	),
		.product(	product			),
		.out_tok(	mlt_out_tok		)
	);

	assign chain_go	= mlt_out_valid & mlt_out_tok.chain;
	assign mlt_done	= mlt_out_valid & ~mlt_out_tok.chain;

	// A chained product owns the adder input; reservation keeps new adds away.
	always_comb begin
		add_in_valid		= accept & is_add;
		add_a				= req.data1;
		add_b				= req.data2;
		add_in_tok.issue_no	= req.issue_no;
		case (req.op.op_code)
			ma_pkg::OP_ADD:	add_sub = 1'b0;
			ma_pkg::OP_SUB:	add_sub = 1'b1;
			default:		add_sub = 1'b0;
		endcase
		if (chain_go) begin
			add_in_valid		= 1'b1;
			add_a				= product;
			add_b				= mlt_out_tok.addend;
			add_in_tok.issue_no	= mlt_out_tok.issue_no;
			add_sub				= 1'b0;
		end
	end

	ma_add_pipe add_pipe (
		.clock(		clock			),
		.rst_n(		rst_n			),
		.stall(		stall			),
		.in_valid(	add_in_valid	),
		.sub(		add_sub			),
		.a(			add_a			),
		.b(			add_b			),
		.in_tok(	add_in_tok		),
		.out_valid(	add_out_valid	),
		.sum(		sum				),
		.out_tok(	add_out_tok		)
	);

	// The two streams never complete on the same cycle.
	assign res_valid = ~stall & (add_out_valid | mlt_done);

	always_comb begin
		if (add_out_valid) begin
			res.issue_no	= add_out_tok.issue_no;
			res.data		= sum;
		end else begin
			res.issue_no	= mlt_out_tok.issue_no;
			res.data		= product;
		end
	end

endmodule

// File: test/ma_tb_ref.svh
// Reference model of the multiply-add unit and the typed compare tasks of its testbench.
`ifndef MA_TB_REF_SVH
`define MA_TB_REF_SVH

// Expected result word, all arithmetic wraps at 32 bits.
function automatic ma_pkg::data_t ref_result(input ma_pkg::op_t op, input ma_pkg::data_t d1,
		input ma_pkg::data_t d2, input ma_pkg::data_t d3, input ma_pkg::data_t bias);
	ma_pkg::data_t prod;
	ma_pkg::data_t result;
	prod = d1 * d2;
	if (op.op_class == ma_pkg::OP_CLASS_ADD) begin
		result = (op.op_code == ma_pkg::OP_SUB) ? d1 - d2 : d1 + d2;
	end else begin
		case (op.op_code)
			ma_pkg::OP_MAD:	result = prod + d3;
			ma_pkg::OP_MAC:	result = prod + bias;	// Bias as seen at acceptance.
			default:		result = prod;
		endcase
	end
	return result;
endfunction

// Unstalled cycles from acceptance to the result.
function automatic int ref_latency(input ma_pkg::op_t op);
	int lat;
	if (op.op_class == ma_pkg::OP_CLASS_ADD) begin
		lat = ma_pkg::LAT_ADD;
	end else if (op.op_code == ma_pkg::OP_MAD || op.op_code == ma_pkg::OP_MAC) begin
		lat = ma_pkg::LAT_CHAIN;
	end else begin
		lat = ma_pkg::LAT_MLT;
	end
	return lat;
endfunction

task automatic check_res(input ma_pkg::ma_res_t got, input ma_pkg::ma_res_t exp);
	if (got !== exp) begin
		stop_run($sformatf("[ERROR] %0t: result tag %0d data %h, expected tag %0d data %h",
			$time, got.issue_no, got.data, exp.issue_no, exp.data));
	end
endtask

task automatic check_data(input ma_pkg::data_t got, input ma_pkg::data_t exp, input string what);
	if (got !== exp) begin
		stop_run($sformatf("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp));
	end
endtask

`endif

// File: test/ma_tb.sv
// Testbench for the multiply-add unit with its Wishbone register block.
`timescale 1ns/1ps

module ma_tb;

	localparam int N_BASIC	= 40;
	localparam int N_CHAIN	= 20;
	localparam int N_MIXED	= 40;
	localparam int N_STALL	= 40;
	localparam int N_TOTAL	= N_BASIC + N_CHAIN + N_MIXED + N_STALL;

	logic				clock;
	logic				rst_n;
	logic				stall;
	logic				req_valid;
	logic				req_ready;
	logic				res_valid;
	ma_pkg::ma_req_t	req;
	ma_pkg::ma_res_t	res;
	ma_pkg::wb_req_t	wb_i;
	ma_pkg::wb_rsp_t	wb_o;

	ma_pkg::ma_res_t	exp_res [256];
	int					due_at [256];
	bit					pending [256];
	int					active_cnt;
	int					accepted;
	int					retired;
	ma_pkg::data_t		bias_model;
	ma_pkg::issue_no_t	next_tag;
	bit					stall_run;

	`include "ma_tb_ref.svh"

	ma_top ma_top_inst (
		.clock(clock), .rst_n(rst_n), .stall(stall),
		.req_valid(req_valid), .req(req), .req_ready(req_ready),
		.res_valid(res_valid), .res(res), .wb_i(wb_i), .wb_o(wb_o)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		#(N_TOTAL * 200 + 2000);
		stop_run("Timeout: the run did not finish in the expected time.");
	end

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Scoreboard, sampled mid-cycle where every DUT output is settled.
	always @(negedge clock) begin
		if (rst_n) begin
			if (!stall) begin
				active_cnt = active_cnt + 1;
			end
			if (stall && res_valid) begin
				stop_run($sformatf("[ERROR] %0t: res_valid high during stall", $time));
			end
			if (res_valid) begin
				if (!pending[res.issue_no]) begin
					stop_run($sformatf("A result came back with unknown tag %0d.", res.issue_no));
				end
				check_res(res, exp_res[res.issue_no]);
				if (active_cnt != due_at[res.issue_no]) begin
					stop_run($sformatf("[ERROR] %0t: tag %0d completed in the wrong cycle",
						$time, res.issue_no));
				end
				pending[res.issue_no] = 1'b0;
				retired = retired + 1;
			end
			if (req_valid && req_ready) begin
				exp_res[req.issue_no].issue_no = req.issue_no;
				exp_res[req.issue_no].data = ref_result(req.op, req.data1, req.data2,
					req.data3, bias_model);
				due_at[req.issue_no] = active_cnt + ref_latency(req.op);
				pending[req.issue_no] = 1'b1;
				accepted = accepted + 1;
			end
		end
	end

	function automatic ma_pkg::op_t random_op(input int lo, input int hi);
		ma_pkg::op_t o;
		case ($urandom_range(hi, lo))
			0:			o = '{ma_pkg::OP_CLASS_ADD, ma_pkg::OP_ADD};
			1:			o = '{ma_pkg::OP_CLASS_ADD, ma_pkg::OP_SUB};
			2:			o = '{ma_pkg::OP_CLASS_MLT, ma_pkg::OP_MUL};
			3:			o = '{ma_pkg::OP_CLASS_MLT, ma_pkg::OP_MAD};
			default:	o = '{ma_pkg::OP_CLASS_MLT, ma_pkg::OP_MAC};
		endcase
		return o;
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	// Holds the request until the DUT takes it.
	task automatic send_req(input ma_pkg::op_t op);
		bit taken;
		taken = 1'b0;
		req.op = op;
		req.issue_no = next_tag;
		req.data1 = $urandom;
		req.data2 = $urandom;
		req.data3 = $urandom;
		req_valid = 1'b1;
		while (!taken) begin
			@(negedge clock);
			taken = req_ready;
		end
		@(posedge clock);
		#1;
		req_valid = 1'b0;
		next_tag++;
	endtask

	task automatic wb_cycle(input bit we, input ma_pkg::wb_adr_t adr, input ma_pkg::data_t wdata,
			output ma_pkg::data_t rdata);
		bit acked;
		acked = 1'b0;
		wb_i.cyc = 1'b1;
		wb_i.stb = 1'b1;
		wb_i.we = we;
		wb_i.adr = adr;
		wb_i.dat_w = wdata;
		while (!acked) begin
			@(negedge clock);
			acked = wb_o.ack;
		end
		rdata = wb_o.dat_r;
		@(posedge clock);
		#1;
		wb_i = '0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (accepted != retired) begin
			@(posedge clock);
			waited++;
			if (waited > 50) begin
				stop_run("Accepted requests were lost and never produced a result.");
			end
		end
		idle_cycles(1);
	endtask

	initial begin
		ma_pkg::data_t	rd;
		int				leftover;
		void'($urandom(32'h2585_5c35));
		rst_n = 1'b0;
		stall = 1'b0;
		req_valid = 1'b0;
		req = '0;
		wb_i = '0;
		active_cnt = 0;
		accepted = 0;
		retired = 0;
		bias_model = '0;
		next_tag = '0;
		stall_run = 1'b0;
		repeat (5) @(posedge clock);
		#1 rst_n = 1'b1;

		// The unit refuses everything until software enables it.
		req.op = random_op(0, 0);
		req_valid = 1'b1;
		repeat (8) begin
			@(negedge clock);
			if (req_ready !== 1'b0) begin
				stop_run($sformatf("[ERROR] %0t: req_ready high before enable", $time));
			end
		end
		idle_cycles(1);
		req_valid = 1'b0;
		wb_cycle(1'b0, ma_pkg::REG_BIAS, '0, rd);
		check_data(rd, '0, "REG_BIAS after reset");
		wb_cycle(1'b1, ma_pkg::REG_CTRL, 32'd1, rd);

		repeat (N_BASIC) begin
			send_req(random_op(0, 2));
			idle_cycles($urandom_range(2, 0));
		end
		wait_drain();

		bias_model = $urandom;
		wb_cycle(1'b1, ma_pkg::REG_BIAS, bias_model, rd);
		repeat (N_CHAIN) send_req(random_op(3, 4));
		wait_drain();

		repeat (N_MIXED) send_req(random_op(0, 4));	// Back to back.
		wait_drain();

		stall_run = 1'b1;
		fork
			begin
				repeat (N_STALL) send_req(random_op(0, 4));
				stall_run = 1'b0;
			end
			begin
				while (stall_run) begin
					stall = ~stall;
					idle_cycles($urandom_range(4, 1));
				end
				stall = 1'b0;
			end
		join
		wait_drain();

		wb_cycle(1'b0, ma_pkg::REG_COUNT, '0, rd);
		check_data(rd, ma_pkg::data_t'(accepted), "REG_COUNT");
		leftover = 0;
		foreach (pending[i]) begin
			if (pending[i]) begin
				leftover++;
			end
		end
		if (leftover != 0 || accepted != N_TOTAL) begin
			stop_run($sformatf("%0d of %0d requests accepted, %0d results still outstanding.",
				accepted, N_TOTAL, leftover));
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule
